// File: verilog/demodPkg.sv
`default_nettype none

package demodPkg;

    // demodulation mode select.
    // Code 7 is reserved and decodes like AM.
    typedef enum logic [2:0] {
        modeAm    = 3'd0,
        modePm    = 3'd1,
        modeFm    = 3'd2,
        mode2Fsk  = 3'd3,
        modeBpsk  = 3'd4,
        modeQpsk  = 3'd5,
        modeOqpsk = 3'd6
    } demodMode;

    // two's complement I and Q sample words.
    localparam int sampleWidth = 18;

    // binary angle, 256 counts make one full turn.
    localparam int angleWidth = 8;

    localparam int magWidth = 9;     // unsigned magnitude, includes the cordic gain.

endpackage

`default_nettype wire

// File: verilog/vectorCordic.sv
`timescale 1ns/1ps
`default_nettype none

module vectorCordic #(
    parameter int cordicWidth  = 10,
    parameter int cordicStages = 8
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  ena,
    input  logic signed [cordicWidth-1:0]         xIn,
    input  logic signed [cordicWidth-1:0]         yIn,
    output logic        [demodPkg::magWidth-1:0]  mag,
    output logic        [demodPkg::angleWidth-1:0] phase
);

    // two top bits absorb the negation and the cordic gain.
    localparam int guardBits = 2;
    localparam int dataWidth = cordicWidth + 2 + guardBits;

    // angle accumulator at 2^14 counts per turn to match the atan table.
    localparam int accWidth = 14;
    localparam int fracBits = accWidth - demodPkg::angleWidth;

    localparam logic [accWidth-1:0] halfTurn  = {1'b1, {(accWidth-1){1'b0}}};
    localparam logic [accWidth-1:0] roundHalf = accWidth'(1) << (fracBits - 1);

    // atan(2^-i) in 2^-14 turn units.
    function automatic logic [accWidth-1:0] atanLut(input int stage);
        case (stage)
            0:       atanLut = 14'd2048;
            1:       atanLut = 14'd1209;
            2:       atanLut = 14'd639;
            3:       atanLut = 14'd324;
            4:       atanLut = 14'd163;
            5:       atanLut = 14'd81;
            6:       atanLut = 14'd41;
            7:       atanLut = 14'd20;
            8:       atanLut = 14'd10;
            9:       atanLut = 14'd5;
            default: atanLut = '0;
        endcase
    endfunction

    logic signed [dataWidth-1:0] xExt;
    logic signed [dataWidth-1:0] yExt;

    // index 0 is the pre-rotation register and index k+1 the output of stage k.
    logic signed [dataWidth-1:0] xPipe [0:cordicStages];
    logic signed [dataWidth-1:0] yPipe [0:cordicStages-1];
    logic        [accWidth-1:0]  zPipe [0:cordicStages];
    logic        [accWidth-1:0]  zRound;

    assign xExt = {{2{xIn[cordicWidth-1]}}, xIn, {guardBits{1'b0}}};
    assign yExt = {{2{yIn[cordicWidth-1]}}, yIn, {guardBits{1'b0}}};

    // fold the left half plane over so the stages see x >= 0.
    always_ff @(posedge clk) begin
        if (reset) begin
            xPipe[0] <= '0;
            yPipe[0] <= '0;
            zPipe[0] <= '0;
        end else if (ena) begin
            if (xExt[dataWidth-1]) begin
                xPipe[0] <= -xExt;
                yPipe[0] <= -yExt;
                zPipe[0] <= halfTurn;     // start from 180 degrees.
            end else begin
                xPipe[0] <= xExt;
                yPipe[0] <= yExt;
                zPipe[0] <= '0;
            end
        end
    end

    for (genvar k = 0; k < cordicStages; k++) begin : gStage
        localparam logic [accWidth-1:0] stageAtan = atanLut(k);

        logic signed [dataWidth-1:0] yShift;
        logic                        rotDown;

        assign yShift  = yPipe[k] >>> k;
        assign rotDown = ~yPipe[k][dataWidth-1];  // vector on or above the axis.

        always_ff @(posedge clk) begin
            if (reset) begin
                xPipe[k+1] <= '0;
                zPipe[k+1] <= '0;
            end else if (ena) begin
                if (rotDown) begin
                    xPipe[k+1] <= xPipe[k] + yShift;
                    zPipe[k+1] <= zPipe[k] + stageAtan;
                end else begin
                    xPipe[k+1] <= xPipe[k] - yShift;
                    zPipe[k+1] <= zPipe[k] - stageAtan;
                end
            end
        end

        // the last stage has no use for y.
        if (k < cordicStages - 1) begin : gYReg
            logic signed [dataWidth-1:0] xShift;

            assign xShift = xPipe[k] >>> k;

            always_ff @(posedge clk) begin
                if (reset) begin
                    yPipe[k+1] <= '0;
                end else if (ena) begin
                    if (rotDown) begin
                        yPipe[k+1] <= yPipe[k] - xShift;
                    end else begin
                        yPipe[k+1] <= yPipe[k] + xShift;
                    end
                end
            end
        end
    end

    // round the accumulated angle to the output grid with wrap at one turn.
    assign zRound = zPipe[cordicStages] + roundHalf;
    assign phase  = zRound[accWidth-1 -: demodPkg::angleWidth];

    // final x is never negative, so the sign bit is skipped.
    assign mag = xPipe[cordicStages][dataWidth-2 -: demodPkg::magWidth];

endmodule

`default_nettype wire

// File: verilog/fmDemod.sv
`timescale 1ns/1ps
`default_nettype none

module fmDemod (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sync,
    input  demodPkg::demodMode                  mode,
    input  logic [demodPkg::angleWidth-1:0]     phase,
    output logic [demodPkg::angleWidth-1:0]     phaseError,
    output logic [demodPkg::angleWidth-1:0]     freq,
    output logic [demodPkg::angleWidth-1:0]     freqError
);

    // one eighth of a turn, the QPSK constellation offset.
    localparam logic [demodPkg::angleWidth-1:0] eighthTurn =
        demodPkg::angleWidth'(1) << (demodPkg::angleWidth - 3);

    logic [demodPkg::angleWidth-1:0] qpskPhase;
    logic [demodPkg::angleWidth-1:0] prevPhase;
    logic [demodPkg::angleWidth-1:0] prevPhaseError;
    logic [demodPkg::angleWidth-1:0] phaseDiff;
    logic [demodPkg::angleWidth-1:0] phaseErrorDiff;

    assign qpskPhase = phase - eighthTurn;    // center the symbols on the axes.

    // carrier phase error, with the modulation stripped by mode.
    always_ff @(posedge clk) begin
        if (reset) begin
            phaseError <= '0;
        end else if (sync) begin
            case (mode)
                demodPkg::modeAm: begin
                    phaseError <= '0;         // no carrier phase to track.
                end
                demodPkg::modePm,
                demodPkg::modeFm,
                demodPkg::mode2Fsk: begin
                    phaseError <= phase;
                end
                demodPkg::modeBpsk: begin
                    // doubling the angle folds the two symbols together.
                    phaseError <= phase << 1;
                end
                demodPkg::modeQpsk,
                demodPkg::modeOqpsk: begin
                    phaseError <= qpskPhase << 2;  // four symbols fold to one.
                end
                default: begin
                    phaseError <= '0;
                end
            endcase
        end
    end

    // differences wrap modulo one turn.
    assign phaseDiff      = phase - prevPhase;
    assign phaseErrorDiff = phaseError - prevPhaseError;

    // instantaneous frequency and frequency error as first differences.
    always_ff @(posedge clk) begin
        if (reset) begin
            freq           <= '0;
            freqError      <= '0;
            prevPhase      <= '0;
            prevPhaseError <= '0;
        end else if (sync) begin
            freq           <= phaseDiff;
            freqError      <= phaseErrorDiff;
            prevPhase      <= phase;
            prevPhaseError <= phaseError;
        end
    end

endmodule

`default_nettype wire

// File: verilog/demodTop.sv
`timescale 1ns/1ps
`default_nettype none

module demodTop #(
    parameter int cordicWidth  = 10,
    parameter int cordicStages = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 sync,
    input  logic [demodPkg::sampleWidth-1:0]     iFm,
    input  logic [demodPkg::sampleWidth-1:0]     qFm,
    input  demodPkg::demodMode                   mode,
    output logic [demodPkg::magWidth-1:0]        mag,
    output logic [demodPkg::angleWidth-1:0]      phase,
    output logic [demodPkg::angleWidth-1:0]      phaseError,
    output logic [demodPkg::angleWidth-1:0]      freq,
    output logic [demodPkg::angleWidth-1:0]      freqError
);

    // polar conversion on the top bits of each sample.
    vectorCordic #(
        .cordicWidth  (cordicWidth),
        .cordicStages (cordicStages)
    ) i_cordic (
        .clk   (clk),
        .reset (reset),
        .ena   (sync),
        .xIn   (iFm[demodPkg::sampleWidth-1 -: cordicWidth]),
        .yIn   (qFm[demodPkg::sampleWidth-1 -: cordicWidth]),
        .mag   (mag),
        .phase (phase)
    );

    // phase error and frequency terms from the cordic angle.
    fmDemod i_demod (
        .clk        (clk),
        .reset      (reset),
        .sync       (sync),
        .mode       (mode),
        .phase      (phase),
        .phaseError (phaseError),
        .freq       (freq),
        .freqError  (freqError)
    );

endmodule

`default_nettype wire

// File: sim/demodTopTb.sv
`timescale 1ns/1ps
`default_nettype none

module demodTopTb;

    localparam int cordicWidth    = 10;
    localparam int cordicStages   = 8;
    localparam int sw             = demodPkg::sampleWidth;
    localparam int aw             = demodPkg::angleWidth;
    localparam int outBits        = demodPkg::magWidth + 4 * aw;
    localparam int settleStrobes  = cordicStages + 4;
    localparam int watchdogClocks = 20000;
    localparam int freqSteps [4]  = '{0, 5, -12, 40};
    localparam real pi            = 3.14159265358979;
    localparam real fullScale     = 131072.0;   // largest sample magnitude.
    localparam real cordicGain    = 1.647;
    localparam real magScale      = 1024.0;     // full-scale radius gives 128 counts before gain.

    logic                          clk;
    logic                          reset;
    logic                          sync;
    logic [sw-1:0]                 iFm;
    logic [sw-1:0]                 qFm;
    demodPkg::demodMode            mode;
    logic [demodPkg::magWidth-1:0] mag;
    logic [aw-1:0]                 phase;
    logic [aw-1:0]                 phaseError;
    logic [aw-1:0]                 freq;
    logic [aw-1:0]                 freqError;
    logic [outBits-1:0]            outWord;

    logic          resetCheck;
    logic          checkEnable;
    logic          polarCheck;      // only while the vector is held.
    logic [aw-1:0] expPhase;
    logic [aw-1:0] expFreq;
    int            expMag;
    int            magTol;
    int            errorCount;
    logic [31:0]   lfsrState;

    // reference model state.
    logic [aw-1:0]      modelPhaseError;
    logic [aw-1:0]      peHist1;
    logic [aw-1:0]      peHist2;
    logic [aw-1:0]      expFreqError;
    logic [outBits-1:0] heldOut;
    logic               syncSeen;

    demodTop #(
        .cordicWidth  (cordicWidth),
        .cordicStages (cordicStages)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .sync       (sync),
        .iFm        (iFm),
        .qFm        (qFm),
        .mode       (mode),
        .mag        (mag),
        .phase      (phase),
        .phaseError (phaseError),
        .freq       (freq),
        .freqError  (freqError)
    );

    always #10 clk = ~clk;

    assign outWord      = {mag, phase, phaseError, freq, freqError};
    assign expFreqError = peHist1 - peHist2;   // wraps at one turn.

    // phase error rule per mode, as a binary angle.
    function automatic logic [aw-1:0] expectedPhaseError(input demodPkg::demodMode m,
                                                         input logic [aw-1:0] p);
        logic [aw-1:0] offset;
        offset = p - aw'(32);    // eighth of a turn.
        case (m)
            demodPkg::modePm, demodPkg::modeFm, demodPkg::mode2Fsk: return p;
            demodPkg::modeBpsk: return {p[aw-2:0], 1'b0};
            demodPkg::modeQpsk, demodPkg::modeOqpsk: return {offset[aw-3:0], 2'b00};
            default: return '0;
        endcase
    endfunction

    function automatic int angleDist(input logic [aw-1:0] a, input logic [aw-1:0] b);
        logic [aw-1:0] d;
        d = a - b;
        if (d[aw-1]) begin
            return 256 - int'(d);
        end
        return int'(d);
    endfunction

    function automatic int absDiff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    // fibonacci lfsr, taps 32 22 2 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int drawBits(input int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    function automatic logic [sw-1:0] toSample(input real value);
        int rounded;
        if (value >= 0.0) begin
            rounded = $rtoi(value + 0.5);
        end else begin
            rounded = -$rtoi(0.5 - value);
        end
        return sw'(rounded);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            modelPhaseError <= '0;
            peHist1         <= '0;
            peHist2         <= '0;
        end else if (sync) begin
            modelPhaseError <= expectedPhaseError(mode, phase);
            peHist1         <= phaseError;   // value before this strobe.
            peHist2         <= peHist1;
        end
        heldOut  <= outWord;
        syncSeen <= sync;
    end

    task automatic reportValue(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        errorCount++;
        $display("Error: %s expected %0h got %0h at %0t", name, expected, actual, $time);
    endtask

    task automatic reportNear(input string name, input logic [63:0] expected, input int tol,
                              input logic [63:0] actual);
        errorCount++;
        $display("Error: %s expected %0h within %0d counts got %0h at %0t",
                 name, expected, tol, actual, $time);
    endtask

    resetZero: assert property (@(posedge clk) disable iff (!resetCheck) outWord == '0)
        else reportValue("outputs after reset", 64'(0), 64'($sampled(outWord)));

    holdLevels: assert property (@(posedge clk) disable iff (!checkEnable)
        syncSeen || outWord == heldOut)
        else reportValue("held outputs", 64'($sampled(heldOut)), 64'($sampled(outWord)));

    phaseErrorRule: assert property (@(posedge clk) disable iff (!checkEnable)
        phaseError == modelPhaseError)
        else reportValue("phaseError", 64'($sampled(modelPhaseError)),
                         64'($sampled(phaseError)));

    freqErrorDiff: assert property (@(posedge clk) disable iff (!checkEnable)
        freqError == expFreqError)
        else reportValue("freqError", 64'($sampled(expFreqError)), 64'($sampled(freqError)));

    phaseNear: assert property (@(posedge clk) disable iff (!(checkEnable && polarCheck))
        angleDist(phase, expPhase) <= 2)
        else reportNear("phase", 64'($sampled(expPhase)), 2, 64'($sampled(phase)));

    magNear: assert property (@(posedge clk) disable iff (!(checkEnable && polarCheck))
        absDiff(int'(mag), expMag) <= magTol)
        else reportNear("mag", 64'($sampled(expMag)), $sampled(magTol), 64'($sampled(mag)));

    freqNear: assert property (@(posedge clk) disable iff (!checkEnable)
        angleDist(freq, expFreq) <= 2)
        else reportNear("freq", 64'($sampled(expFreq)), 2, 64'($sampled(freq)));

    // one sync pulse, then idle up to the next strobe slot.
    task automatic strobe(input int spacing);
        sync = 1'b1;
        @(negedge clk);
        sync = 1'b0;
        repeat (spacing - 1) @(negedge clk);
    endtask

    task automatic setPolarExpect();
        real iv;
        real qv;
        real turns;
        iv    = real'($signed(iFm));
        qv    = real'($signed(qFm));
        turns = $atan2(qv, iv) / (2.0 * pi);
        if (turns < 0.0) begin
            turns = turns + 1.0;
        end
        expPhase = aw'($rtoi(turns * 256.0 + 0.5));    // 256 wraps to 0.
        expMag   = $rtoi(cordicGain * $sqrt(iv * iv + qv * qv) / magScale + 0.5);
        magTol   = $rtoi(0.03 * real'(expMag)) + 2;
    endtask

    // phasor advancing by step binary-angle counts per strobe.
    task automatic runPhasor(input demodPkg::demodMode m, input real amplitude,
                             input int startAngle, input int step, input int strobes,
                             input bit irregularGap);
        real turns;
        int  spacing;
        checkEnable = 1'b0;
        polarCheck  = (step == 0);
        mode        = m;
        expFreq     = aw'(step);
        for (int n = 0; n < strobes; n++) begin
            turns = real'(startAngle + n * step) / 256.0;
            iFm   = toSample(amplitude * fullScale * $cos(2.0 * pi * turns));
            qFm   = toSample(amplitude * fullScale * $sin(2.0 * pi * turns));
            if (n == 0) begin
                setPolarExpect();
            end
            if (n == settleStrobes) begin
                checkEnable = 1'b1;
            end
            spacing = 4;
            if (irregularGap && n == strobes - 2) begin
                spacing = 5 + drawBits(5);
            end
            strobe(spacing);
        end
    endtask

    initial begin
        real amplitude;
        int  startAngle;
        clk         = 1'b0;
        reset       = 1'b1;
        sync        = 1'b0;
        iFm         = '0;
        qFm         = '0;
        mode        = demodPkg::modeAm;
        resetCheck  = 1'b0;
        checkEnable = 1'b0;
        polarCheck  = 1'b0;
        expPhase    = '0;
        expFreq     = '0;
        expMag      = 0;
        magTol      = 0;
        errorCount  = 0;
        lfsrState   = 32'he3fb_d860;

        repeat (3) @(negedge clk);
        reset      = 1'b0;
        resetCheck = 1'b1;
        @(negedge clk);
        resetCheck = 1'b0;

        // held vectors, two per quadrant.
        for (int quad = 0; quad < 4; quad++) begin
            for (int r = 0; r < 2; r++) begin
                amplitude  = 0.25 + 0.7 * real'(drawBits(8)) / 256.0;
                startAngle = quad * 64 + drawBits(6);
                runPhasor(demodPkg::modePm, amplitude, startAngle, 0, settleStrobes + 4,
                          quad == 2 && r == 1);
            end
        end

        for (int s = 0; s < 4; s++) begin
            amplitude  = 0.6 + 0.35 * real'(drawBits(8)) / 256.0;
            startAngle = drawBits(8);
            runPhasor(demodPkg::modeFm, amplitude, startAngle, freqSteps[s],
                      settleStrobes + 8, 1'b0);
        end

        // every mode code on one held vector.
        amplitude  = 0.5 + 0.4 * real'(drawBits(8)) / 256.0;
        startAngle = drawBits(8);
        for (int m = 0; m < 8; m++) begin
            runPhasor(demodPkg::demodMode'(3'(m)), amplitude, startAngle, 0,
                      settleStrobes + 4, 1'b0);
        end

        // rotating carrier under the phase-folding modes.
        runPhasor(demodPkg::modeBpsk, 0.8, drawBits(8), 3, settleStrobes + 8, 1'b0);
        runPhasor(demodPkg::modeQpsk, 0.8, drawBits(8), -9, settleStrobes + 8, 1'b1);

        checkEnable = 1'b0;
        @(negedge clk);
        $display("checks done, errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        for (int c = 0; c < watchdogClocks; c++) begin
            @(posedge clk);
        end
        $display("timeout: stimulus did not finish within %0d clocks", watchdogClocks);
        $display("checks done, errors: %0d", errorCount);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/demodPkg.sv
verilog/vectorCordic.sv
verilog/fmDemod.sv
verilog/demodTop.sv
sim/demodTopTb.sv

// File: Makefile
# Verilator flow for the demodulator front end.
# Any variable can be overridden, e.g. make sim TOP=demodTopTb OBJDIR=build

VERILATOR ?= verilator
TOP       ?= demodTopTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output.
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
